// File: rtl/snake_pkg.sv
package snake_pkg;

    // ------------------------------------------------------------------------
    // Playfield geometry
    // ------------------------------------------------------------------------
    localparam int CELL_SIZE = 32;
    localparam int GRID_COLS = 20;
    localparam int GRID_ROWS = 15;
    localparam int PIX_W     = 10;
    localparam int COORD_W   = 5;

    // Segment storage and length counter
    localparam int MAX_LEN = 100;
    localparam int LEN_W   = 7;

    // Start layout, head first with the body trailing to the left
    localparam int START_ROW      = 7;
    localparam int START_HEAD_COL = 10;
    localparam int START_LEN      = 3;

    localparam int APPLE_INIT_ROW = 5;
    localparam int APPLE_INIT_COL = 5;

    // Taps 15, 13, 12, 10 with a left shift
    localparam logic [15:0] LFSR_SEED = 16'hBEEF;

    // Timing in frame ticks
    localparam int MOVE_DIV_W   = 3;
    localparam int DEATH_FRAMES = 40;
    localparam int DEATH_CNT_W  = 6;

    localparam int SCORE_DIGITS = 8;

    // ------------------------------------------------------------------------
    // Colours, 4 bits each of R, G, B
    // ------------------------------------------------------------------------
    localparam logic [11:0] COL_DARK_SQ  = 12'h020;
    localparam logic [11:0] COL_LIGHT_SQ = 12'h040;
    localparam logic [11:0] COL_APPLE    = 12'hF00;
    localparam logic [11:0] COL_SNAKE    = 12'h0F0;
    localparam logic [11:0] COL_FLASH    = 12'hF00;
    localparam logic [11:0] COL_BLACK    = 12'h000;

    typedef enum logic [1:0] {
        GS_START,
        GS_PLAY,
        GS_DEATH,
        GS_GAMEOVER
    } game_state_t;

    typedef enum logic [1:0] {
        DIR_UP,
        DIR_DOWN,
        DIR_LEFT,
        DIR_RIGHT
    } dir_t;

endpackage

// File: rtl/snake_ctrl.sv
`timescale 1ns/100ps

module snake_ctrl
    import snake_pkg::*;
(
    input  logic        clk_pix,
    input  logic        reset,
    input  logic        frame_tick,
    input  logic        btn_up,
    input  logic        btn_down,
    input  logic        btn_left,
    input  logic        btn_right,
    input  logic        btn_center,
    input  logic        collide,
    output game_state_t game_state,
    output dir_t        dir,
    output logic        move_step,
    output logic        flash_on
);

    // Bit order is up, down, left, right, center from bit 0
    logic [4:0]             btn_now;
    logic [4:0]             btn_prev;
    logic [4:0]             btn_edge;
    logic [MOVE_DIV_W-1:0]  move_div;
    logic [DEATH_CNT_W-1:0] death_cnt;
    logic                   death_done;

    assign btn_now  = {btn_center, btn_right, btn_left, btn_down, btn_up};
    assign btn_edge = btn_now & ~btn_prev;

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            btn_prev <= '0;
        end else begin
            btn_prev <= btn_now;
        end
    end

    // ------------------------------------------------------------------------
    // Game FSM
    // ------------------------------------------------------------------------
    assign death_done = frame_tick && death_cnt == DEATH_CNT_W'(DEATH_FRAMES);

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            game_state <= GS_START;
        end else begin
            case (game_state)
                GS_START:    if (btn_edge[4]) game_state <= GS_PLAY;
                GS_PLAY:     if (move_step && collide) game_state <= GS_DEATH;
                GS_DEATH:    if (death_done) game_state <= GS_GAMEOVER;
                GS_GAMEOVER: if (btn_edge[4]) game_state <= GS_START;
                default:     game_state <= GS_START;
            endcase
        end
    end

    // Turns by priority; a press opposite to the heading falls through
    always_ff @(posedge clk_pix) begin
        if (reset || game_state == GS_START) begin
            dir <= DIR_RIGHT;
        end else if (game_state == GS_PLAY) begin
            if (btn_edge[0] && dir != DIR_DOWN) begin
                dir <= DIR_UP;
            end else if (btn_edge[1] && dir != DIR_UP) begin
                dir <= DIR_DOWN;
            end else if (btn_edge[2] && dir != DIR_RIGHT) begin
                dir <= DIR_LEFT;
            end else if (btn_edge[3] && dir != DIR_LEFT) begin
                dir <= DIR_RIGHT;
            end
        end
    end

    // Move divider restarts at zero on each entry to play
    always_ff @(posedge clk_pix) begin
        if (reset || game_state != GS_PLAY) begin
            move_div <= '0;
        end else if (frame_tick) begin
            move_div <= move_div + 1'b1;
        end
    end

    assign move_step = frame_tick && game_state == GS_PLAY && move_div == '0;

    // Counts frame ticks since the collision and holds at the limit
    always_ff @(posedge clk_pix) begin
        if (reset || game_state != GS_DEATH) begin
            death_cnt <= '0;
        end else if (frame_tick && !death_done) begin
            death_cnt <= death_cnt + 1'b1;
        end
    end

    // Red phase for eight ticks out of sixteen
    assign flash_on = game_state == GS_DEATH && death_cnt[3];

    a_step_in_play: assert property (@(posedge clk_pix) disable iff (reset)
        move_step |-> game_state == GS_PLAY);

endmodule

// File: rtl/snake_body.sv
`timescale 1ns/100ps

module snake_body
    import snake_pkg::*;
(
    input  logic               clk_pix,
    input  logic               reset,
    input  game_state_t        game_state,
    input  dir_t               dir,
    input  logic               move_step,
    input  logic [COORD_W-1:0] apple_row,
    input  logic [COORD_W-1:0] apple_col,
    input  logic [COORD_W-1:0] cell_row,
    input  logic [COORD_W-1:0] cell_col,
    output logic               collide,
    output logic               ate,
    output logic [LEN_W-1:0]   snake_len,
    output logic               snake_here
);

    // Index 0 is the head
    logic [COORD_W-1:0] seg_row [MAX_LEN];
    logic [COORD_W-1:0] seg_col [MAX_LEN];
    logic [COORD_W-1:0] next_row;
    logic [COORD_W-1:0] next_col;
    logic               wall_hit;
    logic               self_hit;

    // Stepping off the top or left wraps to 31, which the wall test catches
    always_comb begin
        next_row = seg_row[0];
        next_col = seg_col[0];
        case (dir)
            DIR_UP:   next_row = seg_row[0] - 1'b1;
            DIR_DOWN: next_row = seg_row[0] + 1'b1;
            DIR_LEFT: next_col = seg_col[0] - 1'b1;
            default:  next_col = seg_col[0] + 1'b1;
        endcase
    end

    assign wall_hit = next_row >= COORD_W'(GRID_ROWS) || next_col >= COORD_W'(GRID_COLS);

    // ------------------------------------------------------------------------
    // Segment match for the next head and for the renderer's cell
    // ------------------------------------------------------------------------
    always_comb begin
        self_hit   = 1'b0;
        snake_here = 1'b0;
        for (int i = 0; i < MAX_LEN; i++) begin
            if (i < int'(snake_len)) begin
                if (seg_row[i] == next_row && seg_col[i] == next_col) begin
                    self_hit = 1'b1;
                end
                if (seg_row[i] == cell_row && seg_col[i] == cell_col) begin
                    snake_here = 1'b1;
                end
            end
        end
    end

    assign collide = move_step && (wall_hit || self_hit);
    assign ate     = move_step && !(wall_hit || self_hit) &&
                     next_row == apple_row && next_col == apple_col;

    always_ff @(posedge clk_pix) begin
        if (reset || game_state == GS_START) begin
            snake_len <= LEN_W'(START_LEN);
        end else if (ate && snake_len < LEN_W'(MAX_LEN)) begin
            snake_len <= snake_len + 1'b1;
        end
    end

    // Whole list shifts on a move, so growth keeps the old tail at index len
    always_ff @(posedge clk_pix) begin
        if (game_state == GS_START) begin
            for (int i = 0; i < START_LEN; i++) begin
                seg_row[i] <= COORD_W'(START_ROW);
                seg_col[i] <= COORD_W'(START_HEAD_COL - i);
            end
        end else if (move_step && !collide) begin
            for (int i = MAX_LEN - 1; i > 0; i--) begin
                seg_row[i] <= seg_row[i-1];
                seg_col[i] <= seg_col[i-1];
            end
            seg_row[0] <= next_row;
            seg_col[0] <= next_col;
        end
    end

    a_len_range: assert property (@(posedge clk_pix) disable iff (reset)
        snake_len >= LEN_W'(START_LEN) && snake_len <= LEN_W'(MAX_LEN));

endmodule

// File: rtl/apple_spawner.sv
`timescale 1ns/100ps

module apple_spawner
    import snake_pkg::*;
(
    input  logic               clk_pix,
    input  logic               reset,
    input  logic               frame_tick,
    input  logic               ate,
    output logic [COORD_W-1:0] apple_row,
    output logic [COORD_W-1:0] apple_col
);

    logic [15:0] lfsr;
    logic        lfsr_fb;

    assign lfsr_fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

    // Free running in every state
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            lfsr <= LFSR_SEED;
        end else if (frame_tick) begin
            lfsr <= {lfsr[14:0], lfsr_fb};
        end
    end

    // New cell taken from the LFSR value before this tick's shift
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            apple_row <= COORD_W'(APPLE_INIT_ROW);
            apple_col <= COORD_W'(APPLE_INIT_COL);
        end else if (ate) begin
            apple_row <= lfsr[4:0] % COORD_W'(GRID_ROWS);
            apple_col <= lfsr[9:5] % COORD_W'(GRID_COLS);
        end
    end

    a_apple_in_grid: assert property (@(posedge clk_pix) disable iff (reset)
        apple_row < COORD_W'(GRID_ROWS) && apple_col < COORD_W'(GRID_COLS));

endmodule

// File: rtl/bcd_score.sv
`timescale 1ns/100ps

module bcd_score
    import snake_pkg::*;
(
    input  logic        clk_pix,
    input  logic        reset,
    input  game_state_t game_state,
    input  logic        ate,
    output logic [3:0]  score_d0,
    output logic [3:0]  score_d1,
    output logic [3:0]  score_d2,
    output logic [3:0]  score_d3,
    output logic [3:0]  score_d4,
    output logic [3:0]  score_d5,
    output logic [3:0]  score_d6,
    output logic [3:0]  score_d7
);

    // Digit 0 is the least significant
    logic [SCORE_DIGITS-1:0][3:0] digit;
    logic [SCORE_DIGITS-1:0][3:0] digit_inc;
    logic                         carry;
    logic                         all_nines;

    // Ripple a decimal carry up from digit 0
    always_comb begin
        carry     = 1'b1;
        all_nines = 1'b1;
        for (int i = 0; i < SCORE_DIGITS; i++) begin
            if (carry && digit[i] == 4'd9) begin
                digit_inc[i] = 4'd0;
            end else begin
                digit_inc[i] = digit[i] + {3'b000, carry};
                carry        = 1'b0;
            end
            all_nines = all_nines && digit[i] == 4'd9;
        end
    end

    // Holds at 99999999
    always_ff @(posedge clk_pix) begin
        if (reset || game_state == GS_START) begin
            digit <= '0;
        end else if (ate && !all_nines) begin
            digit <= digit_inc;
        end
    end

    assign score_d0 = digit[0];
    assign score_d1 = digit[1];
    assign score_d2 = digit[2];
    assign score_d3 = digit[3];
    assign score_d4 = digit[4];
    assign score_d5 = digit[5];
    assign score_d6 = digit[6];
    assign score_d7 = digit[7];

endmodule

// File: rtl/cell_renderer.sv
`timescale 1ns/100ps

module cell_renderer
    import snake_pkg::*;
(
    input  logic [PIX_W-1:0]   pixel_x,
    input  logic [PIX_W-1:0]   pixel_y,
    input  logic               display_en,
    input  game_state_t        game_state,
    input  logic               flash_on,
    input  logic [COORD_W-1:0] apple_row,
    input  logic [COORD_W-1:0] apple_col,
    input  logic               snake_here,
    output logic [COORD_W-1:0] cell_row,
    output logic [COORD_W-1:0] cell_col,
    output logic [3:0]         vga_r,
    output logic [3:0]         vga_g,
    output logic [3:0]         vga_b
);

    logic [11:0] colour;

    assign cell_row = COORD_W'(pixel_y / CELL_SIZE);
    assign cell_col = COORD_W'(pixel_x / CELL_SIZE);

    // Later layers override earlier ones
    always_comb begin
        if (cell_row[0] ^ cell_col[0]) begin
            colour = COL_DARK_SQ;
        end else begin
            colour = COL_LIGHT_SQ;
        end
        if (cell_row == apple_row && cell_col == apple_col) begin
            colour = COL_APPLE;
        end
        if (snake_here) begin
            colour = COL_SNAKE;
        end
        if (game_state == GS_DEATH && flash_on) begin
            colour = COL_FLASH;
        end
        // Blanking and the game-over screen
        if (!display_en || game_state == GS_GAMEOVER) begin
            colour = COL_BLACK;
        end
    end

    assign {vga_r, vga_g, vga_b} = colour;

endmodule

// File: rtl/snake_game.sv
`timescale 1ns/100ps

module snake_game
    import snake_pkg::*;
(
    input  logic             clk_pix,
    input  logic             reset,
    input  logic             frame_tick,
    input  logic             btn_up,
    input  logic             btn_down,
    input  logic             btn_left,
    input  logic             btn_right,
    input  logic             btn_center,
    input  logic [PIX_W-1:0] pixel_x,
    input  logic [PIX_W-1:0] pixel_y,
    input  logic             display_en,
    output logic [3:0]       vga_r,
    output logic [3:0]       vga_g,
    output logic [3:0]       vga_b,
    output logic [3:0]       score_d0,
    output logic [3:0]       score_d1,
    output logic [3:0]       score_d2,
    output logic [3:0]       score_d3,
    output logic [3:0]       score_d4,
    output logic [3:0]       score_d5,
    output logic [3:0]       score_d6,
    output logic [3:0]       score_d7
);

    game_state_t        game_state;
    dir_t               dir;
    logic               move_step;
    logic               flash_on;
    logic               collide;
    logic               ate;
    logic               snake_here;
    logic [COORD_W-1:0] apple_row;
    logic [COORD_W-1:0] apple_col;
    logic [COORD_W-1:0] cell_row;
    logic [COORD_W-1:0] cell_col;

    snake_ctrl u_ctrl (
        .clk_pix    (clk_pix),
        .reset      (reset),
        .frame_tick (frame_tick),
        .btn_up     (btn_up),
        .btn_down   (btn_down),
        .btn_left   (btn_left),
        .btn_right  (btn_right),
        .btn_center (btn_center),
        .collide    (collide),
        .game_state (game_state),
        .dir        (dir),
        .move_step  (move_step),
        .flash_on   (flash_on)
    );

    snake_body u_body (
        .clk_pix    (clk_pix),
        .reset      (reset),
        .game_state (game_state),
        .dir        (dir),
        .move_step  (move_step),
        .apple_row  (apple_row),
        .apple_col  (apple_col),
        .cell_row   (cell_row),
        .cell_col   (cell_col),
        .collide    (collide),
        .ate        (ate),
        .snake_len  (),
        .snake_here (snake_here)
    );

    apple_spawner u_apple (
        .clk_pix    (clk_pix),
        .reset      (reset),
        .frame_tick (frame_tick),
        .ate        (ate),
        .apple_row  (apple_row),
        .apple_col  (apple_col)
    );

    bcd_score u_score (
        .clk_pix    (clk_pix),
        .reset      (reset),
        .game_state (game_state),
        .ate        (ate),
        .score_d0   (score_d0),
        .score_d1   (score_d1),
        .score_d2   (score_d2),
        .score_d3   (score_d3),
        .score_d4   (score_d4),
        .score_d5   (score_d5),
        .score_d6   (score_d6),
        .score_d7   (score_d7)
    );

    cell_renderer u_render (
        .pixel_x    (pixel_x),
        .pixel_y    (pixel_y),
        .display_en (display_en),
        .game_state (game_state),
        .flash_on   (flash_on),
        .apple_row  (apple_row),
        .apple_col  (apple_col),
        .snake_here (snake_here),
        .cell_row   (cell_row),
        .cell_col   (cell_col),
        .vga_r      (vga_r),
        .vga_g      (vga_g),
        .vga_b      (vga_b)
    );

endmodule

// File: include/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// ----------------------------------------------------------------------------
// Compare tasks for the DUT outputs
// ----------------------------------------------------------------------------

task automatic stop_with_fail();
    $display(">>> FAIL");
    $fatal(1, "Simulation stopped after a failure");
endtask

// Colour is {vga_r, vga_g, vga_b}
task automatic check_colour(
    input int          rec,
    input logic [11:0] got,
    input logic [11:0] exp
);
    if (got !== exp) begin
        error_count++;
        $display("CHECK FAILED at time %0t: record %0d colour %03h, expected %03h",
                 $time, rec, got, exp);
        stop_with_fail();
    end
endtask

// Score digits packed d7 down to d0
task automatic check_score(
    input int          rec,
    input logic [31:0] got,
    input logic [31:0] exp
);
    if (got !== exp) begin
        error_count++;
        $display("CHECK FAILED at time %0t: record %0d score %08h, expected %08h",
                 $time, rec, got, exp);
        stop_with_fail();
    end
endtask

`endif

// File: tests/tb_snake_game.sv
`timescale 1ns/100ps

module tb_snake_game
    import snake_pkg::*;
();

    localparam int MAX_RECS = 64;

    logic             clk_pix;
    logic             reset;
    logic             frame_tick;
    logic             btn_up;
    logic             btn_down;
    logic             btn_left;
    logic             btn_right;
    logic             btn_center;
    logic [PIX_W-1:0] pixel_x;
    logic [PIX_W-1:0] pixel_y;
    logic             display_en;
    logic [3:0]       vga_r;
    logic [3:0]       vga_g;
    logic [3:0]       vga_b;
    logic [3:0]       score_d0;
    logic [3:0]       score_d1;
    logic [3:0]       score_d2;
    logic [3:0]       score_d3;
    logic [3:0]       score_d4;
    logic [3:0]       score_d5;
    logic [3:0]       score_d6;
    logic [3:0]       score_d7;

    // Trace records, one per probe
    int          rec_wait  [MAX_RECS];
    logic [4:0]  rec_btn   [MAX_RECS];
    int          rec_px    [MAX_RECS];
    int          rec_py    [MAX_RECS];
    logic        rec_de    [MAX_RECS];
    logic [11:0] rec_col   [MAX_RECS];
    logic [31:0] rec_score [MAX_RECS];
    int          num_recs;
    int          error_count;
    int          watchdog_ns;

    `include "tb_checks.svh"

    snake_game u_snake_game (
        .clk_pix    (clk_pix),
        .reset      (reset),
        .frame_tick (frame_tick),
        .btn_up     (btn_up),
        .btn_down   (btn_down),
        .btn_left   (btn_left),
        .btn_right  (btn_right),
        .btn_center (btn_center),
        .pixel_x    (pixel_x),
        .pixel_y    (pixel_y),
        .display_en (display_en),
        .vga_r      (vga_r),
        .vga_g      (vga_g),
        .vga_b      (vga_b),
        .score_d0   (score_d0),
        .score_d1   (score_d1),
        .score_d2   (score_d2),
        .score_d3   (score_d3),
        .score_d4   (score_d4),
        .score_d5   (score_d5),
        .score_d6   (score_d6),
        .score_d7   (score_d7)
    );

    initial begin
        clk_pix = 1'b0;
        forever #2 clk_pix = ~clk_pix;
    end

    // One-cycle frame tick every fourth clock once reset is released
    initial begin
        frame_tick = 1'b0;
        @(negedge reset);
        forever begin
            repeat (3) @(posedge clk_pix);
            #1 frame_tick = 1'b1;
            @(posedge clk_pix);
            #1 frame_tick = 1'b0;
        end
    end

    // ------------------------------------------------------------------------
    // Trace reader and stimulus
    // ------------------------------------------------------------------------
    task automatic load_trace();
        int          fd;
        int          n;
        int          w;
        int          px;
        int          py;
        int          de;
        logic [4:0]  b;
        logic [11:0] col;
        logic [31:0] sc;
        string       line;
        fd       = $fopen("tests/snake_trace.txt", "r");
        num_recs = 0;
        if (fd == 0) begin
            $display("Could not open the trace file tests/snake_trace.txt");
            stop_with_fail();
        end
        while (!$feof(fd) && num_recs < MAX_RECS) begin
            line = "";
            n    = $fgets(line, fd);
            if (line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%d %b %d %d %d %h %h", w, b, px, py, de, col, sc);
                if (n == 7) begin
                    rec_wait[num_recs]  = w;
                    rec_btn[num_recs]   = b;
                    rec_px[num_recs]    = px;
                    rec_py[num_recs]    = py;
                    rec_de[num_recs]    = de[0];
                    rec_col[num_recs]   = col;
                    rec_score[num_recs] = sc;
                    num_recs++;
                end
            end
        end
        $fclose(fd);
    endtask

    // Returns on the clock edge where the DUT samples the tick
    task automatic wait_frame_tick();
        @(posedge clk_pix);
        while (!frame_tick) @(posedge clk_pix);
    endtask

    task automatic run_record(input int idx);
        if (rec_wait[idx] == 0) begin
            @(posedge clk_pix);
        end else begin
            repeat (rec_wait[idx]) wait_frame_tick();
        end
        #1;
        {btn_center, btn_right, btn_left, btn_down, btn_up} = rec_btn[idx];
        pixel_x    = PIX_W'(rec_px[idx]);
        pixel_y    = PIX_W'(rec_py[idx]);
        display_en = rec_de[idx];
        // Buttons are held for two clocks
        if (rec_btn[idx] != 5'b00000) begin
            @(posedge clk_pix);
            @(posedge clk_pix);
            #1;
            {btn_center, btn_right, btn_left, btn_down, btn_up} = 5'b00000;
        end
        #1;
        check_colour(idx, {vga_r, vga_g, vga_b}, rec_col[idx]);
        check_score(idx, {score_d7, score_d6, score_d5, score_d4,
                          score_d3, score_d2, score_d1, score_d0}, rec_score[idx]);
    endtask

    initial begin
        int total_ticks;
        reset       = 1'b1;
        btn_up      = 1'b0;
        btn_down    = 1'b0;
        btn_left    = 1'b0;
        btn_right   = 1'b0;
        btn_center  = 1'b0;
        pixel_x     = '0;
        pixel_y     = '0;
        display_en  = 1'b0;
        error_count = 0;
        watchdog_ns = 0;
        load_trace();
        total_ticks = 0;
        for (int i = 0; i < num_recs; i++) begin
            total_ticks += rec_wait[i] + 1;
        end
        // Four clocks of 4 ns per frame tick, plus margin
        watchdog_ns = total_ticks * 4 * 4 + 4000;
        repeat (4) @(posedge clk_pix);
        #1 reset = 1'b0;
        for (int i = 0; i < num_recs; i++) begin
            run_record(i);
        end
        if (error_count == 0 && num_recs > 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display("No trace records were run or a check failed");
            stop_with_fail();
        end
    end

    initial begin
        wait (watchdog_ns != 0);
        #(watchdog_ns);
        $display("Simulation hung: trace not finished after %0d ns", watchdog_ns);
        stop_with_fail();
    end

endmodule

// File: tests/snake_trace.txt
# wait_ticks buttons(center right left down up) pixel_x pixel_y display_en colour score(d7..d0)
# Probe pixels sit at cell centres, col*32+16 and row*32+16
0  00000 336 240 1 0f0 00000000
0  00000 304 240 1 0f0 00000000
0  00000 272 240 1 0f0 00000000
0  00000 176 176 1 f00 00000000
0  00000 16  16  1 040 00000000
0  00000 48  16  1 020 00000000
0  00000 336 240 0 000 00000000
1  10000 336 240 1 0f0 00000000
1  00000 368 240 1 0f0 00000000
0  00000 272 240 1 020 00000000
1  00100 368 240 1 0f0 00000000
7  00000 400 240 1 0f0 00000000
0  00000 304 240 1 040 00000000
1  00001 400 240 1 0f0 00000000
7  00000 400 208 1 0f0 00000000
0  00000 336 240 1 020 00000000
8  00000 400 176 1 0f0 00000000
1  00100 400 176 1 0f0 00000000
55 00000 176 176 1 0f0 00000001
0  00000 144 368 1 f00 00000001
0  00000 272 176 1 0f0 00000001
48 00000 16  176 1 0f0 00000001
8  00000 16  16  1 f00 00000001
8  00000 16  16  1 040 00000001
24 00000 16  16  1 f00 00000001
1  00000 16  16  1 000 00000001
0  00000 16  176 1 000 00000001
1  10000 336 240 1 0f0 00000000
0  00000 272 240 1 0f0 00000000
0  00000 16  176 1 020 00000000
0  00000 176 176 1 040 00000000
0  00000 144 368 1 f00 00000000

// File: sources.f
+incdir+include
rtl/snake_pkg.sv
rtl/snake_ctrl.sv
rtl/snake_body.sv
rtl/apple_spawner.sv
rtl/bcd_score.sv
rtl/cell_renderer.sv
rtl/snake_game.sv
tests/tb_snake_game.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module tb_snake_game -o sim_snake

# The pipe status is that of tee, so a fatal stop still reaches the log search
./obj_dir/sim_snake | tee sim.log

if grep -q ">>> FAIL" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation finished without failure"
